// ==== source/l2_cache_settings.svh ====
`ifndef L2_CACHE_SETTINGS_SVH
`define L2_CACHE_SETTINGS_SVH

// byte address width on both sides.
`define L2_ADDR_BITS 32

// byte offset bits within one line.
`define L2_S_OFFSET 5

// set index bits.
`define L2_S_INDEX 3

// associativity, fixed at four by the tree plru.
`define L2_NUM_WAYS 4

// one cache line.
`define L2_LINE_BITS 256

// derived sizes.
`define L2_S_TAG (`L2_ADDR_BITS - `L2_S_OFFSET - `L2_S_INDEX)
`define L2_NUM_SETS (1 << `L2_S_INDEX)

`endif

// ==== source/l2_cache_pkg.sv ====
`include "l2_cache_settings.svh"

package l2_cache_pkg;

  // byte address from the arbiter or to physical memory.
  typedef logic [`L2_ADDR_BITS-1:0] addr_t;

  // address fields.
  typedef logic [`L2_S_TAG-1:0] tag_t;
  typedef logic [`L2_S_INDEX-1:0] index_t;

  // whole line, the unit of every transfer.
  typedef logic [`L2_LINE_BITS-1:0] line_t;

  // way number and one-hot way strobe.
  typedef logic [$clog2(`L2_NUM_WAYS)-1:0] way_t;
  typedef logic [`L2_NUM_WAYS-1:0] way_mask_t;

  // tree pseudo-lru, one bit per internal node.
  typedef logic [`L2_NUM_WAYS-2:0] plru_t;

  // controller states.
  typedef enum logic [2:0] {
    idle      = 3'd0,
    compare   = 3'd1,
    writeback = 3'd2,
    fill      = 3'd3,
    respond   = 3'd4
  } l2_state_t;

endpackage : l2_cache_pkg

// ==== source/l2_ctrl_if.sv ====
interface l2_ctrl_if import l2_cache_pkg::*; ();

  // status from the datapath.
  logic hit;
  way_t hit_way;
  logic victim_dirty;

  // array write strobes.
  logic load_tag;
  logic load_valid;
  logic load_dirty;
  logic dirty_value;
  logic load_line;

  // selects.
  logic line_from_mem;
  logic addr_from_victim;
  logic update_lru;

  modport ctrl (
    input  hit, hit_way, victim_dirty,
    output load_tag, load_valid, load_dirty, dirty_value, load_line,
    output line_from_mem, addr_from_victim, update_lru
  );

  modport dp (
    output hit, hit_way, victim_dirty,
    input  load_tag, load_valid, load_dirty, dirty_value, load_line,
    input  line_from_mem, addr_from_victim, update_lru
  );

endinterface : l2_ctrl_if

// ==== source/l2_plru.sv ====
`include "l2_cache_settings.svh"

module l2_plru import l2_cache_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  index_t index,
  input  way_t   access_way,
  input  logic   update,
  output way_t   victim_way
);

  plru_t plru_state [`L2_NUM_SETS];
  plru_t cur_state;
  plru_t next_state;

  assign cur_state = plru_state[index];

  // point every node on the path away from the accessed way.
  always_comb begin
    next_state = cur_state;
    if (access_way < way_t'(2)) begin
      next_state[0] = 1'b1;
      next_state[1] = (access_way == way_t'(0));
    end else begin
      next_state[0] = 1'b0;
      next_state[2] = (access_way == way_t'(2));
    end
  end

  // bit0 picks the half, then bit1 or bit2 picks the way in it.
  assign victim_way = cur_state[0] ? {1'b1, cur_state[2]} : {1'b0, cur_state[1]};

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `L2_NUM_SETS; s++) begin
        plru_state[s] <= '0;
      end
    end else if (update) begin
      plru_state[index] <= next_state;
    end
  end

endmodule : l2_plru

// ==== source/l2_cache_datapath.sv ====
`include "l2_cache_settings.svh"

module l2_cache_datapath import l2_cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  l2_ctrl_if.dp ctrl,
  input  addr_t mem_address,
  input  line_t mem_wdata,
  output line_t mem_rdata,
  input  line_t pmem_rdata,
  output addr_t pmem_address,
  output line_t pmem_wdata
);

  // ******************************
  // arrays and address fields
  // ******************************

  tag_t  tag_array   [`L2_NUM_WAYS][`L2_NUM_SETS];
  logic  valid_array [`L2_NUM_WAYS][`L2_NUM_SETS];
  logic  dirty_array [`L2_NUM_WAYS][`L2_NUM_SETS];
  line_t line_array  [`L2_NUM_WAYS][`L2_NUM_SETS];

  tag_t      req_tag;
  index_t    req_index;
  way_t      plru_victim;
  way_t      replace_way;
  way_t      way_sel;
  way_mask_t write_mask;
  line_t     line_in;
  tag_t      addr_tag;

  assign req_index = mem_address[`L2_S_OFFSET +: `L2_S_INDEX];
  assign req_tag   = mem_address[`L2_ADDR_BITS-1 -: `L2_S_TAG];

  // ******************************
  // lookup and victim choice
  // ******************************

  always_comb begin
    ctrl.hit     = 1'b0;
    ctrl.hit_way = '0;
    for (int w = 0; w < `L2_NUM_WAYS; w++) begin
      if (valid_array[w][req_index] && (tag_array[w][req_index] == req_tag)) begin
        ctrl.hit     = 1'b1;
        ctrl.hit_way = way_t'(w);
      end
    end
  end

  l2_plru plru (
    .clk        (clk),
    .reset      (reset),
    .index      (req_index),
    .access_way (ctrl.hit_way),
    .update     (ctrl.update_lru),
    .victim_way (plru_victim)
  );

  // an empty way beats the plru choice; lowest one wins.
  always_comb begin
    replace_way = plru_victim;
    for (int w = `L2_NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_array[w][req_index]) begin
        replace_way = way_t'(w);
      end
    end
  end

  assign ctrl.victim_dirty = valid_array[replace_way][req_index] &&
                             dirty_array[replace_way][req_index];

  // ******************************
  // array writes
  // ******************************

  // hits write their own way, fills write the victim.
  assign way_sel    = ctrl.hit ? ctrl.hit_way : replace_way;
  assign write_mask = way_mask_t'(1) << way_sel;
  assign line_in    = ctrl.line_from_mem ? pmem_rdata : mem_wdata;

  always_ff @(posedge clk) begin
    for (int w = 0; w < `L2_NUM_WAYS; w++) begin
      if (write_mask[w]) begin
        if (ctrl.load_tag) begin
          tag_array[w][req_index] <= req_tag;
        end
        if (ctrl.load_line) begin
          line_array[w][req_index] <= line_in;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < `L2_NUM_WAYS; w++) begin
        for (int s = 0; s < `L2_NUM_SETS; s++) begin
          valid_array[w][s] <= 1'b0;
          dirty_array[w][s] <= 1'b0;
        end
      end
    end else begin
      for (int w = 0; w < `L2_NUM_WAYS; w++) begin
        if (write_mask[w]) begin
          if (ctrl.load_valid) begin
            valid_array[w][req_index] <= 1'b1;
          end
          if (ctrl.load_dirty) begin
            dirty_array[w][req_index] <= ctrl.dirty_value;
          end
        end
      end
    end
  end

  // ******************************
  // host and memory side
  // ******************************

  assign mem_rdata = line_array[ctrl.hit_way][req_index];

  // line aligned, victim tag on writeback.
  assign addr_tag     = ctrl.addr_from_victim ? tag_array[replace_way][req_index] : req_tag;
  assign pmem_address = {addr_tag, req_index, {`L2_S_OFFSET{1'b0}}};
  assign pmem_wdata   = line_array[replace_way][req_index];

endmodule : l2_cache_datapath

// ==== source/l2_cache_control.sv ====
module l2_cache_control import l2_cache_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  l2_ctrl_if.ctrl ctrl,
  input  logic    mem_read,
  input  logic    mem_write,
  output logic    mem_resp,
  input  logic    pmem_resp,
  output logic    pmem_read,
  output logic    pmem_write
);

  l2_state_t state;
  l2_state_t next_state;

  // ******************************
  // state register
  // ******************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  // ******************************
  // next state and outputs
  // ******************************

  always_comb begin
    next_state            = state;
    ctrl.load_tag         = 1'b0;
    ctrl.load_valid       = 1'b0;
    ctrl.load_dirty       = 1'b0;
    ctrl.dirty_value      = 1'b0;
    ctrl.load_line        = 1'b0;
    ctrl.line_from_mem    = 1'b0;
    ctrl.addr_from_victim = 1'b0;
    ctrl.update_lru       = 1'b0;
    mem_resp              = 1'b0;
    pmem_read             = 1'b0;
    pmem_write            = 1'b0;

    case (state)
      idle: begin
        if (mem_read || mem_write) begin
          next_state = compare;
        end
      end

      compare: begin
        if (ctrl.hit) begin
          ctrl.update_lru = 1'b1;
          // write hit takes the whole host line and marks it dirty.
          if (mem_write) begin
            ctrl.load_line   = 1'b1;
            ctrl.load_dirty  = 1'b1;
            ctrl.dirty_value = 1'b1;
          end
          next_state = respond;
        end else if (ctrl.victim_dirty) begin
          next_state = writeback;
        end else begin
          next_state = fill;
        end
      end

      writeback: begin
        pmem_write            = 1'b1;
        ctrl.addr_from_victim = 1'b1;
        if (pmem_resp) begin
          next_state = fill;
        end
      end

      fill: begin
        pmem_read = 1'b1;
        if (pmem_resp) begin
          ctrl.load_tag      = 1'b1;
          ctrl.load_valid    = 1'b1;
          ctrl.load_line     = 1'b1;
          ctrl.line_from_mem = 1'b1;
          ctrl.load_dirty    = 1'b1;
          ctrl.dirty_value   = 1'b0;
          // back to compare, which now hits.
          next_state = compare;
        end
      end

      respond: begin
        mem_resp   = 1'b1;
        next_state = idle;
      end

      default: begin
        next_state = idle;
      end
    endcase
  end

endmodule : l2_cache_control

// ==== source/l2_cache.sv ====
module l2_cache import l2_cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,

  // arbiter side.
  input  addr_t mem_address,
  input  line_t mem_wdata,
  input  logic  mem_read,
  input  logic  mem_write,
  output line_t mem_rdata,
  output logic  mem_resp,

  // physical memory side.
  output addr_t pmem_address,
  output line_t pmem_wdata,
  input  line_t pmem_rdata,
  output logic  pmem_read,
  output logic  pmem_write,
  input  logic  pmem_resp
);

  l2_ctrl_if ctrl_bus ();

  l2_cache_control control (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl_bus.ctrl),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_resp   (mem_resp),
    .pmem_resp  (pmem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write)
  );

  l2_cache_datapath datapath (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl_bus.dp),
    .mem_address  (mem_address),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .pmem_rdata   (pmem_rdata),
    .pmem_address (pmem_address),
    .pmem_wdata   (pmem_wdata)
  );

endmodule : l2_cache

// ==== tests/pmem_model.sv ====
`include "l2_cache_settings.svh"

module pmem_model import l2_cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  addr_t pmem_address,
  input  line_t pmem_wdata,
  input  logic  pmem_read,
  input  logic  pmem_write,
  output line_t pmem_rdata,
  output logic  pmem_resp
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_DELAY = 6;

  // lines written back so far; the rest read as their fill pattern.
  line_t lines [addr_t];

  logic  busy    = 1'b0;
  int    delay   = 0;
  logic  resp_q  = 1'b0;
  line_t rdata_q = '0;

  assign pmem_resp  = resp_q;
  assign pmem_rdata = rdata_q;

  // every word depends on the whole line address.
  function automatic line_t initial_line(addr_t addr);
    line_t l;
    for (int i = 0; i < `L2_LINE_BITS / 32; i++) begin
      l[32*i +: 32] = (addr * (2 * i + 1)) ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1e995;
    end
    return l;
  endfunction

  // one request at a time, answered 1 to 6 cycles after it is seen.
  always @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      resp_q <= 1'b0;
    end else begin
      resp_q <= 1'b0;
      if (busy) begin
        if (delay <= 1) begin
          busy   <= 1'b0;
          resp_q <= 1'b1;
          if (pmem_write) begin
            lines[pmem_address] = pmem_wdata;
          end else begin
            rdata_q <= lines.exists(pmem_address) ? lines[pmem_address]
                                                  : initial_line(pmem_address);
          end
        end else begin
          delay <= delay - 1;
        end
      end else if ((pmem_read || pmem_write) && !resp_q) begin
        busy  <= 1'b1;
        delay <= $urandom_range(MAX_DELAY, 1);
      end
    end
  end

endmodule : pmem_model

// ==== tests/l2_cache_tb.sv ====
`include "l2_cache_settings.svh"

module l2_cache_tb import l2_cache_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 4;
  localparam int MAX_DELAY    = 6;
  localparam int RANDOM_OPS   = 300;
  localparam int NUM_OPS      = 10 + RANDOM_OPS;
  // writeback and fill with handshake turnaround, then compare, respond and the host gap.
  localparam int OP_CYCLES    = 2 * (MAX_DELAY + 2) + 4;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + (NUM_OPS + 1) * OP_CYCLES;

  typedef struct packed {
    line_t data;
    addr_t addr;
    addr_t wb_addr;
    logic  hit;
    logic  wb;
    int    issue_cycle;
  } expect_t;

  logic  clk;
  logic  reset;
  logic  mem_read;
  logic  mem_write;
  logic  mem_resp;
  logic  pmem_read;
  logic  pmem_write;
  logic  pmem_resp;
  addr_t mem_address;
  addr_t pmem_address;
  line_t mem_wdata;
  line_t mem_rdata;
  line_t pmem_wdata;
  line_t pmem_rdata;

  int errors = 0;
  int responses = 0;
  int cycle_count = 0;
  int test_start_errors = 0;

  expect_t expect_q [$];
  addr_t   fill_q [$];
  addr_t   wb_addr_q [$];
  line_t   wb_data_q [$];

  // memory as the host sees it, plus a copy of the directory.
  line_t shadow [addr_t];
  line_t wb_image [addr_t];
  logic  ref_valid [`L2_NUM_WAYS][`L2_NUM_SETS];
  logic  ref_dirty [`L2_NUM_WAYS][`L2_NUM_SETS];
  tag_t  ref_tag [`L2_NUM_WAYS][`L2_NUM_SETS];
  plru_t ref_plru [`L2_NUM_SETS];

  l2_cache uut (.*);
  pmem_model mem_model (.*);

  // 100 ns period.
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ******************************
  // reference model
  // ******************************

  function automatic line_t initial_line(addr_t addr);
    line_t l;
    for (int i = 0; i < `L2_LINE_BITS / 32; i++) begin
      l[32*i +: 32] = (addr * (2 * i + 1)) ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1e995;
    end
    return l;
  endfunction

  function automatic line_t random_line();
    line_t l;
    for (int i = 0; i < `L2_LINE_BITS / 32; i++) begin
      l[32*i +: 32] = $urandom;
    end
    return l;
  endfunction

  // lookup, victim choice and tree update for one access.
  function automatic line_t ref_access(input addr_t addr, input logic is_write,
                                       input line_t wdata, output logic hit,
                                       output logic wb, output addr_t wb_addr);
    index_t idx;
    tag_t   tag;
    addr_t  line_addr;
    way_t   way;
    plru_t  p;
    idx       = addr[`L2_S_OFFSET +: `L2_S_INDEX];
    tag       = addr[`L2_ADDR_BITS-1 -: `L2_S_TAG];
    line_addr = {tag, idx, {`L2_S_OFFSET{1'b0}}};
    p         = ref_plru[idx];
    hit       = 1'b0;
    wb        = 1'b0;
    wb_addr   = '0;
    way       = p[0] ? way_t'(2 + p[2]) : way_t'(p[1]);
    for (int w = `L2_NUM_WAYS - 1; w >= 0; w--) begin
      if (!ref_valid[w][idx]) way = way_t'(w);
    end
    for (int w = 0; w < `L2_NUM_WAYS; w++) begin
      if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
        hit = 1'b1;
        way = way_t'(w);
      end
    end
    if (!hit) begin
      if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
        wb                = 1'b1;
        wb_addr           = {ref_tag[way][idx], idx, {`L2_S_OFFSET{1'b0}}};
        wb_image[wb_addr] = shadow[wb_addr];
      end
      ref_valid[way][idx] = 1'b1;
      ref_tag[way][idx]   = tag;
      ref_dirty[way][idx] = 1'b0;
    end
    // point the tree away from the accessed way.
    if (way < 2) begin
      p[0] = 1'b1;
      p[1] = (way == 0);
    end else begin
      p[0] = 1'b0;
      p[2] = (way == 2);
    end
    ref_plru[idx] = p;
    if (is_write) begin
      shadow[line_addr]   = wdata;
      ref_dirty[way][idx] = 1'b1;
    end
    return shadow.exists(line_addr) ? shadow[line_addr] : initial_line(line_addr);
  endfunction

  // ******************************
  // stimulus and checks
  // ******************************

  task automatic log_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic issue_access(input addr_t addr, input logic is_write, input line_t wdata);
    expect_t e;
    logic    hit;
    logic    wb;
    addr_t   wb_addr;
    @(negedge clk);
    e.data        = ref_access(addr, is_write, wdata, hit, wb, wb_addr);
    e.addr        = addr;
    e.hit         = hit;
    e.wb          = wb;
    e.wb_addr     = wb_addr;
    e.issue_cycle = cycle_count;
    expect_q.push_back(e);
    mem_address = addr;
    mem_wdata   = wdata;
    mem_read    = !is_write;
    mem_write   = is_write;
    do begin
      @(negedge clk);
    end while (!mem_resp);
  endtask

  task automatic end_test(input string name);
    @(negedge clk);
    mem_read  = 1'b0;
    mem_write = 1'b0;
    $display("%s %0d errors", name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  // records memory traffic and checks every host response.
  always @(negedge clk) begin
    expect_t e;
    if (!reset && pmem_resp && pmem_read) fill_q.push_back(pmem_address);
    if (!reset && pmem_resp && pmem_write) begin
      if (fill_q.size() != 0) begin
        log_error($sformatf("writeback of address %h came after the fill", pmem_address));
      end
      wb_addr_q.push_back(pmem_address);
      wb_data_q.push_back(pmem_wdata);
    end
    if (!reset && mem_resp) begin
      if (expect_q.size() == 0) begin
        log_error("response seen with no request outstanding");
      end else begin
        e = expect_q.pop_front();
        responses++;
        if (mem_rdata !== e.data) begin
          log_error($sformatf("FAILED mem_rdata: got %h expected %h", mem_rdata, e.data));
        end
        if (e.hit && cycle_count - e.issue_cycle != 2) begin
          log_error($sformatf("hit on address %h answered after %0d cycles instead of 2",
                              e.addr, cycle_count - e.issue_cycle));
        end
        if (e.hit && fill_q.size() + wb_addr_q.size() != 0) begin
          log_error($sformatf("hit on address %h caused memory traffic", e.addr));
        end else if (!e.hit && fill_q.size() != 1) begin
          log_error($sformatf("miss on address %h saw %0d fills", e.addr, fill_q.size()));
        end else if (!e.hit && fill_q[0] !== {e.addr[31:5], 5'h00}) begin
          log_error($sformatf("FAILED pmem_address: got %h expected %h",
                              fill_q[0], {e.addr[31:5], 5'h00}));
        end
        if (wb_addr_q.size() != int'(e.wb)) begin
          log_error($sformatf("address %h expected %0d writebacks and saw %0d",
                              e.addr, e.wb, wb_addr_q.size()));
        end else if (e.wb && wb_addr_q[0] !== e.wb_addr) begin
          log_error($sformatf("FAILED pmem_address: got %h expected %h",
                              wb_addr_q[0], e.wb_addr));
        end else if (e.wb && wb_data_q[0] !== wb_image[e.wb_addr]) begin
          log_error($sformatf("FAILED pmem_wdata: got %h expected %h",
                              wb_data_q[0], wb_image[e.wb_addr]));
        end
        fill_q.delete();
        wb_addr_q.delete();
        wb_data_q.delete();
      end
    end
  end

  initial begin : stimulus
    tag_t                      rtag;
    index_t                    ridx;
    logic [`L2_S_OFFSET-1:0]   roff;
    logic                      rwrite;
    clk         = 1'b0;
    reset       = 1'b1;
    mem_address = '0;
    mem_wdata   = '0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    void'($urandom(32'hba64d4e6));
    for (int s = 0; s < `L2_NUM_SETS; s++) begin
      ref_plru[s] = '0;
      for (int w = 0; w < `L2_NUM_WAYS; w++) begin
        ref_valid[w][s] = 1'b0;
        ref_dirty[w][s] = 1'b0;
        ref_tag[w][s]   = '0;
      end
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    if (mem_resp !== 1'b0) begin
      log_error($sformatf("FAILED mem_resp: got %h expected 0", mem_resp));
    end
    if (pmem_read !== 1'b0) begin
      log_error($sformatf("FAILED pmem_read: got %h expected 0", pmem_read));
    end
    if (pmem_write !== 1'b0) begin
      log_error($sformatf("FAILED pmem_write: got %h expected 0", pmem_write));
    end

    // unaligned read into an empty cache.
    issue_access({24'h000a31, 3'd1, 5'h0c}, 1'b0, '0);
    end_test("reset_read");

    issue_access({24'h000a31, 3'd1, 5'h00}, 1'b1, random_line());
    issue_access({24'h000a31, 3'd1, 5'h10}, 1'b0, '0);
    end_test("write_read");

    // fifth tag in set 5 pushes out the written first one.
    issue_access({24'h000b00, 3'd5, 5'h00}, 1'b1, random_line());
    for (int t = 1; t < 5; t++) begin
      issue_access({24'h000b00 + 24'(t), 3'd5, 5'h00}, 1'b0, '0);
    end
    end_test("dirty_evict");

    issue_access({24'h000b00, 3'd5, 5'h00}, 1'b0, '0);
    issue_access({24'h000b02, 3'd5, 5'h00}, 1'b0, '0);
    end_test("clean_evict");

    for (int i = 0; i < RANDOM_OPS; i++) begin
      rtag   = tag_t'(24'h00c000 + $urandom_range(15, 0));
      ridx   = index_t'($urandom_range(7, 0));
      roff   = `L2_S_OFFSET'($urandom_range(31, 0));
      rwrite = ($urandom_range(1, 0) == 1);
      issue_access({rtag, ridx, roff}, rwrite, rwrite ? random_line() : '0);
    end
    foreach (wb_image[a]) begin
      if (mem_model.lines[a] !== wb_image[a]) begin
        log_error($sformatf("FAILED mem_model.lines[%h]: got %h expected %h",
                            a, mem_model.lines[a], wb_image[a]));
      end
    end
    end_test("random_mix");

    $display("%0d responses checked, %0d errors", responses, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : l2_cache_tb

// ==== l2_cache.f ====
+incdir+source
source/l2_cache_pkg.sv
source/l2_ctrl_if.sv
source/l2_plru.sv
source/l2_cache_datapath.sv
source/l2_cache_control.sv
source/l2_cache.sv
tests/pmem_model.sv
tests/l2_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache

sources:
  - include_dirs:
      - source
    files:
      - source/l2_cache_pkg.sv
      - source/l2_ctrl_if.sv
      - source/l2_plru.sv
      - source/l2_cache_datapath.sv
      - source/l2_cache_control.sv
      - source/l2_cache.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/pmem_model.sv
      - tests/l2_cache_tb.sv
